// File: build.f
wb_pkg.sv
wb_if.sv
writeback_control.sv
wb_capture.sv
wb_fifo.sv
reg_file.sv
wb_top.sv
tb_wb_top.sv

// File: tb_wb_top.sv
`default_nettype none

module tb_wb_top;

	localparam int N_ALU = 28;
	localparam int N_LD = 8;
	localparam int N_SET = 8;
	localparam int N_JUMP = 8;
	localparam int N_NOWR = 12;
	localparam int N_STREAM = 200;
	localparam int NUM_TESTS = 6;
	localparam int TOTAL_TXNS = N_ALU + N_LD + N_SET + N_JUMP + N_NOWR + N_STREAM;
	// Reset and register readback fit in the margin
	localparam int MAX_CYCLES = TOTAL_TXNS * 12 + NUM_TESTS * 40 + 300;

	logic        clk;
	logic        rst_n;
	logic        in_req;
	logic        in_ack;
	logic [15:0] in_instr;
	logic [15:0] in_alu;
	logic [15:0] in_mem;
	logic [15:0] in_pc;
	logic        in_flag;
	logic [2:0]  rd_addr;
	logic [15:0] rd_data;

	logic [15:0] model_regs [8];
	integer      seed;
	int          cycles;
	int          pass_count;
	int          fail_count;

	// Opcodes that write the ALU result
	logic [4:0] alu_ops [14] = '{wb_pkg::OP_ADDI, wb_pkg::OP_SUBI, wb_pkg::OP_XORI,
		wb_pkg::OP_ANDNI, wb_pkg::OP_ROLI, wb_pkg::OP_SLLI, wb_pkg::OP_RORI,
		wb_pkg::OP_SRLI, wb_pkg::OP_ALU_ARITH, wb_pkg::OP_ALU_SHIFT, wb_pkg::OP_BTR,
		wb_pkg::OP_LBI, wb_pkg::OP_SLBI, wb_pkg::OP_STU};
	logic [4:0] set_ops [4] = '{wb_pkg::OP_SEQ, wb_pkg::OP_SLT, wb_pkg::OP_SLE,
		wb_pkg::OP_SCO};

	wb_top uut
	(
		.clk      (clk),
		.rst_n    (rst_n),
		.in_req   (in_req),
		.in_ack   (in_ack),
		.in_instr (in_instr),
		.in_alu   (in_alu),
		.in_mem   (in_mem),
		.in_pc    (in_pc),
		.in_flag  (in_flag),
		.rd_addr  (rd_addr),
		.rd_data  (rd_data)
	);

	initial
	begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	// Destination register index or -1 for no write
	function automatic int model_dest(input logic [15:0] instr);
		case (instr[15:11])
			wb_pkg::OP_ADDI, wb_pkg::OP_SUBI, wb_pkg::OP_XORI, wb_pkg::OP_ANDNI,
			wb_pkg::OP_ROLI, wb_pkg::OP_SLLI, wb_pkg::OP_RORI, wb_pkg::OP_SRLI,
			wb_pkg::OP_LD:
				return int'(instr[7:5]);
			wb_pkg::OP_ALU_ARITH, wb_pkg::OP_ALU_SHIFT, wb_pkg::OP_BTR,
			wb_pkg::OP_SEQ, wb_pkg::OP_SLT, wb_pkg::OP_SLE, wb_pkg::OP_SCO:
				return int'(instr[4:2]);
			wb_pkg::OP_LBI, wb_pkg::OP_SLBI, wb_pkg::OP_STU:
				return int'(instr[10:8]);
			wb_pkg::OP_JAL, wb_pkg::OP_JALR:
				return int'(wb_pkg::LINK_REG);
			default:
				return -1;
		endcase
	endfunction

	function automatic logic [15:0] model_value(input logic [15:0] instr,
		input logic [15:0] alu, input logic [15:0] mem, input logic [15:0] pc,
		input logic flag);
		case (instr[15:11])
			wb_pkg::OP_LD:
				return mem;
			wb_pkg::OP_SEQ, wb_pkg::OP_SLT, wb_pkg::OP_SLE, wb_pkg::OP_SCO:
				return {15'd0, flag};
			wb_pkg::OP_JAL, wb_pkg::OP_JALR:
				return pc + 16'd2;
			default:
				return alu;
		endcase
	endfunction

	// Kind 0 ALU, 1 LD, 2 set, 3 jump, 4 non-writing, 5 any opcode
	task automatic pick_op(input int kind, output logic [4:0] op);
		logic [31:0] rnd;
		rnd = $random(seed);
		case (kind)
			0: op = alu_ops[rnd % 14];
			1: op = wb_pkg::OP_LD;
			2: op = set_ops[rnd % 4];
			3: op = rnd[0] ? wb_pkg::OP_JAL : wb_pkg::OP_JALR;
			4:
			begin
				op = rnd[4:0];
				while (model_dest({op, 11'd0}) >= 0)
				begin
					rnd = $random(seed);
					op = rnd[4:0];
				end
			end
			default: op = rnd[4:0];
		endcase
	endtask

	// Starts and returns on a falling edge with in_ack low
	task automatic send_instr(input logic [15:0] instr, input logic [15:0] alu,
		input logic [15:0] mem, input logic [15:0] pc, input logic flag);
		in_instr = instr;
		in_alu = alu;
		in_mem = mem;
		in_pc = pc;
		in_flag = flag;
		in_req = 1'b1;
		do @(negedge clk); while (!in_ack);
		in_req = 1'b0;
		do @(negedge clk); while (in_ack);
	endtask

	task automatic run_test(input string name, input int kind, input int count);
		logic [4:0]  op;
		logic [31:0] rnd;
		logic [15:0] instr;
		logic [15:0] alu;
		logic [15:0] mem;
		logic [15:0] pc;
		logic        flag;
		int          dest;
		int          errors;
		for (int i = 0; i < count; i++)
		begin
			pick_op(kind, op);
			rnd = $random(seed);
			instr = {op, rnd[10:0]};
			rnd = $random(seed);
			alu = rnd[15:0];
			rnd = $random(seed);
			mem = rnd[15:0];
			rnd = $random(seed);
			pc = rnd[15:0];
			rnd = $random(seed);
			flag = rnd[0];
			send_instr(instr, alu, mem, pc, flag);
			dest = model_dest(instr);
			if (dest >= 0)
				model_regs[dest] = model_value(instr, alu, mem, pc, flag);
		end
		repeat (40) @(negedge clk);
		errors = 0;
		for (int r = 0; r < 8; r++)
		begin
			rd_addr = 3'(r);
			@(negedge clk);
			if (rd_data !== model_regs[r])
			begin
				$display("** Error: test %s r%0d expected %h actual %h",
					name, r, model_regs[r], rd_data);
				errors++;
			end
		end
		if (errors == 0)
		begin
			pass_count++;
			$display("Test %s finished, %0d instructions, registers match", name, count);
		end
		else
		begin
			fail_count++;
			$display("Test %s finished, %0d register mismatches", name, errors);
		end
	endtask

	initial
	begin
		cycles = 0;
		while (cycles < MAX_CYCLES)
		begin
			@(posedge clk);
			cycles++;
		end
		$display("Timeout after %0d cycles, a handshake never finished", cycles);
		$display("Testbench failed");
		$finish;
	end

	initial
	begin
		rst_n = 1'b0;
		in_req = 1'b0;
		in_instr = '0;
		in_alu = '0;
		in_mem = '0;
		in_pc = '0;
		in_flag = 1'b0;
		rd_addr = '0;
		seed = 66;
		pass_count = 0;
		fail_count = 0;
		for (int r = 0; r < 8; r++)
			model_regs[r] = '0;
		repeat (5) @(posedge clk);
		@(negedge clk);
		rst_n = 1'b1;

		run_test("alu_writes", 0, N_ALU);
		run_test("load", 1, N_LD);
		run_test("set_flag", 2, N_SET);
		run_test("jump_link", 3, N_JUMP);
		run_test("no_write", 4, N_NOWR);
		run_test("random_stream", 5, N_STREAM);

		$display("Tests passed: %0d, tests failed: %0d", pass_count, fail_count);
		if (fail_count == 0)
			$display("Testbench passed");
		else
			$display("Testbench failed");
		$finish;
	end

endmodule

`default_nettype wire

// File: wb_top.sv
`default_nettype none

module wb_top
(
	input  logic              clk,
	input  logic              rst_n,
	input  logic              in_req,
	output logic              in_ack,
	input  wb_pkg::word_t     in_instr,
	input  wb_pkg::word_t     in_alu,
	input  wb_pkg::word_t     in_mem,
	input  wb_pkg::word_t     in_pc,
	input  logic              in_flag,
	input  wb_pkg::reg_addr_t rd_addr,
	output wb_pkg::word_t     rd_data
);

	wb_if cap_q ();
	wb_if fifo_q ();

	wb_capture u_capture
	(
		.clk      (clk),
		.rst_n    (rst_n),
		.in_req   (in_req),
		.in_ack   (in_ack),
		.in_instr (in_instr),
		.in_alu   (in_alu),
		.in_mem   (in_mem),
		.in_pc    (in_pc),
		.in_flag  (in_flag),
		.cap_q    (cap_q.src)
	);

	wb_fifo u_fifo
	(
		.clk   (clk),
		.rst_n (rst_n),
		.push  (cap_q.dst),
		.pop   (fifo_q.src)
	);

	reg_file u_rf
	(
		.clk     (clk),
		.rst_n   (rst_n),
		.wr      (fifo_q.dst),
		.rd_addr (rd_addr),
		.rd_data (rd_data)
	);

endmodule

`default_nettype wire

// File: reg_file.sv
`default_nettype none

module reg_file
(
	input  logic              clk,
	input  logic              rst_n,
	wb_if.dst                 wr,
	input  wb_pkg::reg_addr_t rd_addr,
	output wb_pkg::word_t     rd_data
);

	localparam int NUM_REGS = 2 ** $bits(wb_pkg::reg_addr_t);

	wb_pkg::word_t regs [NUM_REGS];

	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			for (int i = 0; i < NUM_REGS; i++)
				regs[i] <= '0;
			wr.ack <= 1'b0;
		end
		else if (wr.req && !wr.ack)
		begin
			// One write per handshake, on the new request
			regs[wr.dest] <= wr.data;
			wr.ack <= 1'b1;
		end
		else if (!wr.req && wr.ack)
			wr.ack <= 1'b0;
	end

	assign rd_data = regs[rd_addr];

	a_ack_follows_req: assert property (@(posedge clk) disable iff (!rst_n)
		wr.ack |-> $past(wr.req))
		else $error("reg_file ack without a preceding request");

endmodule

`default_nettype wire

// File: wb_fifo.sv
`default_nettype none

module wb_fifo
(
	input  logic clk,
	input  logic rst_n,
	wb_if.dst    push,
	wb_if.src    pop
);

	typedef logic [wb_pkg::FIFO_PTR_W-1:0] ptr_t;
	typedef logic [wb_pkg::FIFO_PTR_W:0]   count_t;

	typedef enum logic {IN_IDLE, IN_ACK} in_state_t;
	typedef enum logic [1:0] {OUT_IDLE, OUT_REQ, OUT_WAIT} out_state_t;

	wb_pkg::reg_addr_t dest_mem [wb_pkg::FIFO_DEPTH];
	wb_pkg::word_t     data_mem [wb_pkg::FIFO_DEPTH];

	ptr_t       wr_ptr;
	ptr_t       rd_ptr;
	count_t     count;
	logic       full;
	logic       empty;
	logic       do_write;
	logic       do_read;
	in_state_t  in_state;
	out_state_t out_state;

	assign full = (count == count_t'(wb_pkg::FIFO_DEPTH));
	assign empty = (count == '0);

	// Full FIFO holds off the ack
	assign do_write = (in_state == IN_IDLE) && push.req && !full;
	assign do_read = (out_state == OUT_REQ) && pop.ack;

	assign push.ack = (in_state == IN_ACK);
	assign pop.req = (out_state == OUT_REQ);
	assign pop.dest = dest_mem[rd_ptr];
	assign pop.data = data_mem[rd_ptr];

	always_ff @(posedge clk)
	begin
		if (do_write)
		begin
			dest_mem[wr_ptr] <= push.dest;
			data_mem[wr_ptr] <= push.data;
		end
	end

	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			in_state <= IN_IDLE;
			out_state <= OUT_IDLE;
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end
		else
		begin
			if (do_write)
			begin
				wr_ptr <= wr_ptr + ptr_t'(1);
				in_state <= IN_ACK;
			end
			else if ((in_state == IN_ACK) && !push.req)
				in_state <= IN_IDLE;

			case (out_state)
				OUT_IDLE:
					if (!empty)
						out_state <= OUT_REQ;
				OUT_REQ:
					if (pop.ack)
					begin
						rd_ptr <= rd_ptr + ptr_t'(1);
						out_state <= OUT_WAIT;
					end
				default:
					if (!pop.ack)
						out_state <= OUT_IDLE;
			endcase

			count <= count + count_t'(do_write) - count_t'(do_read);
		end
	end

	a_no_overflow: assert property (@(posedge clk) disable iff (!rst_n)
		count <= count_t'(wb_pkg::FIFO_DEPTH))
		else $error("FIFO written while full");

	a_no_underflow: assert property (@(posedge clk) disable iff (!rst_n)
		pop.req |-> !empty)
		else $error("FIFO read while empty");

endmodule

`default_nettype wire

// File: wb_capture.sv
`default_nettype none

module wb_capture
(
	input  logic          clk,
	input  logic          rst_n,
	input  logic          in_req,
	output logic          in_ack,
	input  wb_pkg::word_t in_instr,
	input  wb_pkg::word_t in_alu,
	input  wb_pkg::word_t in_mem,
	input  wb_pkg::word_t in_pc,
	input  logic          in_flag,
	wb_if.src             cap_q
);

	typedef enum logic [1:0] {IDLE, PUSH, WAIT_ACK_LOW, DONE} cap_state_t;

	cap_state_t        state;
	wb_pkg::reg_addr_t wb_dest;
	logic              wb_write;
	wb_pkg::wb_src_t   wb_sel;
	wb_pkg::word_t     sel_data;
	logic              start_push;

	writebackcontrol u_ctrl
	(
		.instr         (in_instr),
		.reg_write     (wb_dest),
		.write_reg     (wb_write),
		.write_reg_sel (wb_sel)
	);

	always_comb
	begin
		case (wb_sel)
			wb_pkg::WB_SRC_MEM:   sel_data = in_mem;
			// Return address is the next instruction
			wb_pkg::WB_SRC_PC:    sel_data = in_pc + wb_pkg::word_t'(2);
			wb_pkg::WB_SRC_FLAGS: sel_data = wb_pkg::word_t'(in_flag);
			default:              sel_data = in_alu;
		endcase
	end

	assign start_push = (state == IDLE) && in_req && wb_write;

	always_ff @(posedge clk)
	begin
		if (start_push)
		begin
			cap_q.dest <= wb_dest;
			cap_q.data <= sel_data;
		end
	end

	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			state <= IDLE;
			in_ack <= 1'b0;
			cap_q.req <= 1'b0;
		end
		else
		begin
			case (state)
				IDLE:
					if (start_push)
					begin
						cap_q.req <= 1'b1;
						state <= PUSH;
					end
					else if (in_req)
					begin
						// Nothing to write, just retire it
						in_ack <= 1'b1;
						state <= DONE;
					end
				PUSH:
					if (cap_q.ack)
					begin
						cap_q.req <= 1'b0;
						in_ack <= 1'b1;
						state <= WAIT_ACK_LOW;
					end
				WAIT_ACK_LOW:
					if (!cap_q.ack)
						state <= DONE;
				DONE:
					if (!in_req)
					begin
						in_ack <= 1'b0;
						state <= IDLE;
					end
				default:
					state <= IDLE;
			endcase
		end
	end

	// Upstream must hold the instruction until acknowledged
	a_instr_stable: assert property (@(posedge clk) disable iff (!rst_n)
		(in_req && !in_ack) |=> $stable(in_instr))
		else $error("in_instr changed during an open handshake");

endmodule

`default_nettype wire

// File: writeback_control.sv
`default_nettype none

module writebackcontrol
(
	input  wb_pkg::word_t     instr,
	output wb_pkg::reg_addr_t reg_write,
	output logic              write_reg,
	output wb_pkg::wb_src_t   write_reg_sel
);

	wb_pkg::opcode_t opcode;

	assign opcode = instr[15:11];

	always_comb
	begin
		case (opcode)
			// I-format ALU ops
			wb_pkg::OP_ADDI, wb_pkg::OP_SUBI, wb_pkg::OP_XORI, wb_pkg::OP_ANDNI,
			wb_pkg::OP_ROLI, wb_pkg::OP_SLLI, wb_pkg::OP_RORI, wb_pkg::OP_SRLI:
			begin
				reg_write = instr[7:5];
				write_reg = 1'b1;
				write_reg_sel = wb_pkg::WB_SRC_ALU;
			end

			// R-format arith and shift, plus bit reverse
			wb_pkg::OP_ALU_ARITH, wb_pkg::OP_ALU_SHIFT, wb_pkg::OP_BTR:
			begin
				reg_write = instr[4:2];
				write_reg = 1'b1;
				write_reg_sel = wb_pkg::WB_SRC_ALU;
			end

			// Set-on-compare
			wb_pkg::OP_SEQ, wb_pkg::OP_SLT, wb_pkg::OP_SLE, wb_pkg::OP_SCO:
			begin
				reg_write = instr[4:2];
				write_reg = 1'b1;
				write_reg_sel = wb_pkg::WB_SRC_FLAGS;
			end

			// Rs is also the target here
			wb_pkg::OP_LBI, wb_pkg::OP_SLBI, wb_pkg::OP_STU:
			begin
				reg_write = instr[10:8];
				write_reg = 1'b1;
				write_reg_sel = wb_pkg::WB_SRC_ALU;
			end

			wb_pkg::OP_LD:
			begin
				reg_write = instr[7:5];
				write_reg = 1'b1;
				write_reg_sel = wb_pkg::WB_SRC_MEM;
			end

			// Link address goes to r7
			wb_pkg::OP_JAL, wb_pkg::OP_JALR:
			begin
				reg_write = wb_pkg::LINK_REG;
				write_reg = 1'b1;
				write_reg_sel = wb_pkg::WB_SRC_PC;
			end

			// Branches, jumps, stores, halt, nop
			default:
			begin
				reg_write = '0;
				write_reg = 1'b0;
				write_reg_sel = wb_pkg::WB_SRC_ALU;
			end
		endcase
	end

endmodule

`default_nettype wire

// File: wb_if.sv
`default_nettype none

// One writeback record, four-phase req/ack
interface wb_if;

	logic              req;
	logic              ack;
	wb_pkg::reg_addr_t dest;
	wb_pkg::word_t     data;

	modport src
	(
		output req,
		output dest,
		output data,
		input  ack
	);

	modport dst
	(
		input  req,
		input  dest,
		input  data,
		output ack
	);

endinterface

`default_nettype wire

// File: wb_pkg.sv
`default_nettype none

package wb_pkg;

	typedef logic [15:0] word_t;
	typedef logic [2:0] reg_addr_t;
	typedef logic [4:0] opcode_t;

	// Where the written value comes from
	typedef enum logic [1:0]
	{
		WB_SRC_ALU   = 2'b00,
		WB_SRC_MEM   = 2'b01,
		WB_SRC_PC    = 2'b10,
		WB_SRC_FLAGS = 2'b11
	} wb_src_t;

	// I-format ALU
	localparam opcode_t OP_ADDI      = 5'b01000;
	localparam opcode_t OP_SUBI      = 5'b01001;
	localparam opcode_t OP_XORI      = 5'b01010;
	localparam opcode_t OP_ANDNI     = 5'b01011;
	localparam opcode_t OP_ROLI      = 5'b10100;
	localparam opcode_t OP_SLLI      = 5'b10101;
	localparam opcode_t OP_RORI      = 5'b10110;
	localparam opcode_t OP_SRLI      = 5'b10111;

	// R-format, function field picks the operation
	localparam opcode_t OP_ALU_ARITH = 5'b11011;
	localparam opcode_t OP_ALU_SHIFT = 5'b11010;
	localparam opcode_t OP_BTR       = 5'b11001;
	localparam opcode_t OP_SEQ       = 5'b11100;
	localparam opcode_t OP_SLT       = 5'b11101;
	localparam opcode_t OP_SLE       = 5'b11110;
	localparam opcode_t OP_SCO       = 5'b11111;

	localparam opcode_t OP_LBI       = 5'b11000;
	localparam opcode_t OP_SLBI      = 5'b10010;
	localparam opcode_t OP_LD        = 5'b10001;
	localparam opcode_t OP_STU       = 5'b10011;
	localparam opcode_t OP_JAL       = 5'b00110;
	localparam opcode_t OP_JALR      = 5'b00111;

	localparam reg_addr_t LINK_REG = 3'd7;

	localparam int FIFO_DEPTH = 4;
	localparam int FIFO_PTR_W = 2;

endpackage

`default_nettype wire
